/* hdl/backendPkg.sv */
`include "backend_params.svh"

package backendPkg;

    typedef enum logic [2:0] {ADD, SUB, AND, XOR, MUL, LI} OpCode;

    typedef logic [$clog2(`ARCH_REGS)-1:0] ArchReg;
    typedef logic [$clog2(`PHYS_REGS)-1:0] PhysReg;
    typedef logic [$clog2(`ROB_DEPTH)-1:0] RobIdx;

    typedef struct packed {
        OpCode       op;
        ArchReg      rd;
        ArchReg      rs1;
        ArchReg      rs2;
        logic [15:0] imm;
    } MicroOp;                  // 28 bits, low bits of the write data

    typedef struct packed {
        OpCode       op;
        logic [15:0] imm;
        PhysReg      prd;
        PhysReg      prs1;
        PhysReg      prs2;
        RobIdx       robIdx;
    } RenamedOp;

    typedef struct packed {
        logic              valid;
        PhysReg            prd;
        RobIdx             robIdx;
        logic [`XLEN-1:0]  result;
    } WbBundle;

    typedef struct packed {
        logic              valid;
        ArchReg            rd;
        logic [`XLEN-1:0]  result;
        PhysReg            freedPrd;   // Previous mapping of rd
    } CommitBundle;

endpackage

/* hdl/backend_params.svh */
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

`define XLEN        32
`define WB_AW       32          // Wishbone address width

`define ARCH_REGS   8
`define PHYS_REGS   16

`define IQ_DEPTH    4
`define ROB_DEPTH   8           // Power of two, pointers wrap

`define MUL_LATENCY 3           // Issue to writeback for MUL

`endif

/* hdl/execUnit.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module execUnit (
    input  logic                  clk,
    input  logic                  rstN_i,
    input  logic                  issueValid_i,
    input  backendPkg::RenamedOp  issueOp_i,
    output logic                  busy_o,
    output backendPkg::WbBundle   wb_o
);
    logic [`XLEN-1:0]    regFile [`PHYS_REGS];
    logic [`XLEN-1:0]    srcA;
    logic [`XLEN-1:0]    srcB;
    logic [`XLEN-1:0]    aluResult;
    logic [`XLEN-1:0]    mulA;
    logic [`XLEN-1:0]    mulB;
    logic [`XLEN-1:0]    mulResult;
    backendPkg::PhysReg  mulPrd;
    backendPkg::RobIdx   mulRob;
    logic                mulStart;
    logic                mulDone;

    assign srcA      = regFile[issueOp_i.prs1];
    assign srcB      = regFile[issueOp_i.prs2];
    assign mulStart  = issueValid_i && issueOp_i.op == backendPkg::MUL;
    assign mulResult = mulA * mulB;             // Low half of the product

    always_comb begin
        case (issueOp_i.op)
            backendPkg::ADD: aluResult = srcA + srcB;
            backendPkg::SUB: aluResult = srcA - srcB;
            backendPkg::AND: aluResult = srcA & srcB;
            backendPkg::XOR: aluResult = srcA ^ srcB;
            backendPkg::LI:  aluResult = `XLEN'(issueOp_i.imm);
            default:         aluResult = '0;
        endcase
    end

    latencyTimer mulTimer (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .start_i (mulStart),
        .busy_o  (busy_o),
        .done_o  (mulDone)
    );

    always_ff @(posedge clk) begin
        if (mulStart) begin
            mulA   <= srcA;
            mulB   <= srcB;
            mulPrd <= issueOp_i.prd;
            mulRob <= issueOp_i.robIdx;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            wb_o <= '0;
        end else begin
            wb_o.valid <= 1'b0;
            if (issueValid_i && !mulStart) begin
                wb_o <= '{valid: 1'b1, prd: issueOp_i.prd, robIdx: issueOp_i.robIdx,
                          result: aluResult};
            end else if (mulDone) begin
                wb_o <= '{valid: 1'b1, prd: mulPrd, robIdx: mulRob, result: mulResult};
            end
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `PHYS_REGS; i++) regFile[i] <= '0;
        end else if (wb_o.valid) begin
            regFile[wb_o.prd] <= wb_o.result;   // Readable the next cycle
        end
    end

    noIssueWhileMul: assert property (@(posedge clk) disable iff (!rstN_i)
        busy_o |-> !issueValid_i);

endmodule

/* hdl/instPort.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module instPort (
    input  logic                clk,
    input  logic                rstN_i,
    input  logic                wbCyc_i,
    input  logic                wbStb_i,
    input  logic                wbWe_i,
    input  logic [`WB_AW-1:0]   wbAdr_i,
    input  logic [`XLEN-1:0]    wbDat_i,
    input  logic                stall_i,
    output logic                wbAck_o,
    output logic [`XLEN-1:0]    wbDat_o,
    output logic                dispatchValid_o,
    output backendPkg::MicroOp  dispatchOp_o
);
    typedef enum logic [1:0] {IDLE, DISPATCH, ACK} PortState;

    PortState state;
    PortState nextState;

    always_comb begin
        nextState = state;
        case (state)
            IDLE:     if (wbCyc_i && wbStb_i) nextState = wbWe_i ? DISPATCH : ACK;
            DISPATCH: if (!stall_i) nextState = ACK;     // Rename takes the op this cycle
            default:  nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) state <= IDLE;
        else state <= nextState;
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && wbCyc_i && wbStb_i && wbWe_i) begin
            dispatchOp_o <= wbDat_i[$bits(backendPkg::MicroOp)-1:0];
        end
    end

    assign dispatchValid_o = state == DISPATCH;
    assign wbAck_o = state == ACK;
    assign wbDat_o = '0;            // Write-only port

    ackInCycle: assert property (@(posedge clk) disable iff (!rstN_i)
        wbAck_o |-> wbCyc_i && wbStb_i);

    // Classic cycle, the master holds its request until ack
    reqStable: assert property (@(posedge clk) disable iff (!rstN_i)
        wbCyc_i && wbStb_i && !wbAck_o |=> $stable({wbWe_i, wbAdr_i, wbDat_i}));

endmodule

/* hdl/issueQueue.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module issueQueue (
    input  logic                  clk,
    input  logic                  rstN_i,
    input  logic                  enq_i,
    input  backendPkg::RenamedOp  enqOp_i,
    input  backendPkg::WbBundle   wb_i,
    input  logic                  execBusy_i,
    output logic                  full_o,
    output logic                  issueValid_o,
    output backendPkg::RenamedOp  issueOp_o
);
    localparam int IW = $clog2(`IQ_DEPTH);
    localparam int CW = $clog2(`IQ_DEPTH + 1);

    backendPkg::RenamedOp   entries [`IQ_DEPTH];   // Entry 0 is the oldest
    logic [CW-1:0]          count;
    logic [`PHYS_REGS-1:0]  busyTab;
    logic [`IQ_DEPTH-1:0]   ready;
    logic [IW-1:0]          selIdx;
    logic [IW-1:0]          wrIdx;
    logic                   anyReady;
    logic                   doIssue;

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            ready[i] = (CW'(i) < count) && (entries[i].op == backendPkg::LI ||
                       (!busyTab[entries[i].prs1] && !busyTab[entries[i].prs2]));
        end
    end

    always_comb begin
        selIdx   = '0;
        anyReady = 1'b0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                selIdx   = IW'(i);
                anyReady = 1'b1;
            end
        end
    end

    assign doIssue      = anyReady && !execBusy_i;
    assign issueValid_o = doIssue;
    assign issueOp_o    = entries[selIdx];
    assign full_o       = count == CW'(`IQ_DEPTH);
    assign wrIdx        = IW'(doIssue ? count - 1'b1 : count);

    // Collapse above the issued slot, then append
    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_DEPTH - 1; i++) begin
            if (doIssue && i >= selIdx) entries[i] <= entries[i + 1];
        end
        if (enq_i) entries[wrIdx] <= enqOp_i;
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            count   <= '0;
            busyTab <= '0;
        end else begin
            count <= count + CW'(enq_i) - CW'(doIssue);
            if (wb_i.valid) busyTab[wb_i.prd] <= 1'b0;
            if (enq_i) busyTab[enqOp_i.prd] <= 1'b1;     // Fresh register, never in flight
        end
    end

endmodule

/* hdl/latencyTimer.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module latencyTimer (
    input  logic clk,
    input  logic rstN_i,
    input  logic start_i,
    output logic busy_o,
    output logic done_o
);
    localparam int CW = $clog2(`MUL_LATENCY) + 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) cnt <= '0;
        else if (start_i) cnt <= CW'(`MUL_LATENCY - 1);
        else if (cnt != '0) cnt <= cnt - 1'b1;
    end

    assign busy_o = cnt != '0;
    assign done_o = cnt == CW'(1);      // Result registered on this cycle

endmodule

/* hdl/miniBackend.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module miniBackend (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    wbCyc_i,
    input  logic                    wbStb_i,
    input  logic                    wbWe_i,
    input  logic [`WB_AW-1:0]       wbAdr_i,
    input  logic [`XLEN-1:0]        wbDat_i,
    output logic                    wbAck_o,
    output logic [`XLEN-1:0]        wbDat_o,
    output backendPkg::CommitBundle commit_o
);
    backendPkg::MicroOp      dispatchOp;
    backendPkg::RenamedOp    renamed;
    backendPkg::RenamedOp    issueOp;
    backendPkg::PhysReg      oldPrd;
    backendPkg::RobIdx       robIdx;
    backendPkg::WbBundle     wb;
    logic dispatchValid, stall, accept;
    logic freeEmpty, iqFull, robFull;
    logic issueValid, execBusy;

    assign stall  = freeEmpty || iqFull || robFull;
    assign accept = dispatchValid && !stall;

    instPort port (
        .clk(clk), .rstN_i(rstN_i), .wbCyc_i(wbCyc_i), .wbStb_i(wbStb_i), .wbWe_i(wbWe_i),
        .wbAdr_i(wbAdr_i), .wbDat_i(wbDat_i), .stall_i(stall), .wbAck_o(wbAck_o),
        .wbDat_o(wbDat_o), .dispatchValid_o(dispatchValid), .dispatchOp_o(dispatchOp)
    );

    renameMap rename (
        .clk(clk), .rstN_i(rstN_i), .dispatchValid_i(dispatchValid), .dispatchOp_i(dispatchOp),
        .robIdx_i(robIdx), .stall_i(stall), .commit_i(commit_o), .renamed_o(renamed),
        .oldPrd_o(oldPrd), .freeEmpty_o(freeEmpty)
    );

    issueQueue iq (
        .clk(clk), .rstN_i(rstN_i), .enq_i(accept), .enqOp_i(renamed), .wb_i(wb),
        .execBusy_i(execBusy), .full_o(iqFull), .issueValid_o(issueValid), .issueOp_o(issueOp)
    );

    execUnit exec (
        .clk(clk), .rstN_i(rstN_i), .issueValid_i(issueValid), .issueOp_i(issueOp),
        .busy_o(execBusy), .wb_o(wb)
    );

    reorderBuffer rob (
        .clk(clk), .rstN_i(rstN_i), .alloc_i(accept), .allocRd_i(dispatchOp.rd),
        .allocOldPrd_i(oldPrd), .wb_i(wb), .allocIdx_o(robIdx), .full_o(robFull),
        .commit_o(commit_o)
    );

endmodule

/* hdl/renameMap.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module renameMap (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    dispatchValid_i,
    input  backendPkg::MicroOp      dispatchOp_i,
    input  backendPkg::RobIdx       robIdx_i,
    input  logic                    stall_i,
    input  backendPkg::CommitBundle commit_i,
    output backendPkg::RenamedOp    renamed_o,
    output backendPkg::PhysReg      oldPrd_o,
    output logic                    freeEmpty_o
);
    localparam int FREE_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int FPW = $clog2(FREE_DEPTH);
    localparam int FCW = $clog2(FREE_DEPTH + 1);

    backendPkg::PhysReg aliasTab [`ARCH_REGS];
    backendPkg::PhysReg freeList [FREE_DEPTH];
    logic [FPW-1:0]     freeHead;
    logic [FPW-1:0]     freeTail;
    logic [FCW-1:0]     freeCount;
    logic               accept;

    assign accept = dispatchValid_i && !stall_i;
    assign freeEmpty_o = freeCount == '0;
    assign oldPrd_o = aliasTab[dispatchOp_i.rd];    // Returned at commit

    always_comb begin
        renamed_o.op     = dispatchOp_i.op;
        renamed_o.imm    = dispatchOp_i.imm;
        renamed_o.prd    = freeList[freeHead];
        renamed_o.prs1   = aliasTab[dispatchOp_i.rs1];   // Read before this op's update
        renamed_o.prs2   = aliasTab[dispatchOp_i.rs2];
        renamed_o.robIdx = robIdx_i;
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                aliasTab[i] <= backendPkg::PhysReg'(i);    // Identity map
            end
        end else if (accept) begin
            aliasTab[dispatchOp_i.rd] <= freeList[freeHead];
        end
    end

    // Circular free list, starts holding the unmapped registers
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                freeList[i] <= backendPkg::PhysReg'(`ARCH_REGS + i);
            end
            freeHead  <= '0;
            freeTail  <= '0;
            freeCount <= FCW'(FREE_DEPTH);
        end else begin
            if (commit_i.valid) begin
                freeList[freeTail] <= commit_i.freedPrd;
                freeTail <= freeTail + 1'b1;
            end
            if (accept) freeHead <= freeHead + 1'b1;
            freeCount <= freeCount + FCW'(commit_i.valid) - FCW'(accept);
        end
    end

    noPopEmpty: assert property (@(posedge clk) disable iff (!rstN_i)
        dispatchValid_i && !stall_i |-> freeCount != '0);

endmodule

/* hdl/reorderBuffer.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module reorderBuffer (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    alloc_i,
    input  backendPkg::ArchReg      allocRd_i,
    input  backendPkg::PhysReg      allocOldPrd_i,
    input  backendPkg::WbBundle     wb_i,
    output backendPkg::RobIdx       allocIdx_o,
    output logic                    full_o,
    output backendPkg::CommitBundle commit_o
);
    localparam int CW = $clog2(`ROB_DEPTH + 1);

    backendPkg::ArchReg  rdArr     [`ROB_DEPTH];
    backendPkg::PhysReg  oldPrdArr [`ROB_DEPTH];
    logic [`XLEN-1:0]    resultArr [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] entValid;
    logic [`ROB_DEPTH-1:0] entDone;
    backendPkg::RobIdx   head;
    backendPkg::RobIdx   tail;
    logic [CW-1:0]       count;
    logic                doCommit;

    assign allocIdx_o = tail;
    assign full_o     = count == CW'(`ROB_DEPTH);
    assign doCommit   = entValid[head] && entDone[head];

    always_comb begin
        commit_o.valid    = doCommit;
        commit_o.rd       = rdArr[head];
        commit_o.result   = resultArr[head];
        commit_o.freedPrd = oldPrdArr[head];
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rdArr[tail]     <= allocRd_i;
            oldPrdArr[tail] <= allocOldPrd_i;
        end
        if (wb_i.valid) resultArr[wb_i.robIdx] <= wb_i.result;
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            entValid <= '0;
            entDone  <= '0;
            head     <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (alloc_i) begin
                entValid[tail] <= 1'b1;
                entDone[tail]  <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (wb_i.valid) entDone[wb_i.robIdx] <= 1'b1;
            if (doCommit) begin
                entValid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            count <= count + CW'(alloc_i) - CW'(doCommit);
        end
    end

    wbToLiveEntry: assert property (@(posedge clk) disable iff (!rstN_i)
        wb_i.valid |-> entValid[wb_i.robIdx]);

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tbBackend \
    -o simBackend \
    && ./obj_dir/simBackend | tee /dev/stderr | grep -q "^No errors$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* test/backendChecker.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module backendChecker (
    input  logic                    clk,
    input  logic                    wbCyc_i,
    input  logic                    wbStb_i,
    input  logic                    wbWe_i,
    input  logic [`XLEN-1:0]        wbDat_i,
    input  logic                    wbAck_i,
    input  logic [`XLEN-1:0]        wbRdDat_i,
    input  backendPkg::CommitBundle commit_i,
    input  logic                    expValid_i,
    input  logic [`XLEN-1:0]        expValue_i,
    input  logic                    endOfTest_i,
    output int                      errorCount_o,
    output int                      ackCount_o,
    output int                      commitCount_o,
    output int                      pending_o
);
    typedef struct packed {
        backendPkg::ArchReg rd;
        logic [`XLEN-1:0]   value;
    } ExpCommit;

    logic [`XLEN-1:0]     archModel [`ARCH_REGS];
    ExpCommit             expQ [$];                 // Program order
    logic                 strobeSeen = 1'b0;
    logic                 endReported = 1'b0;
    logic [`ARCH_REGS-1:0] committedOnce = '0;      // Alias table starts as identity
    int                   errorCount = 0;
    int                   ackCount = 0;
    int                   commitCount = 0;

    assign errorCount_o  = errorCount;
    assign ackCount_o    = ackCount;
    assign commitCount_o = commitCount;
    assign pending_o     = ackCount - commitCount;

    initial begin
        for (int i = 0; i < `ARCH_REGS; i++) archModel[i] = '0;
    end

    function automatic logic [`XLEN-1:0] modelResult(input backendPkg::MicroOp uop);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        a = archModel[uop.rs1];
        b = archModel[uop.rs2];
        case (uop.op)
            backendPkg::ADD: return a + b;
            backendPkg::SUB: return a - b;
            backendPkg::AND: return a & b;
            backendPkg::XOR: return a ^ b;
            backendPkg::MUL: return a * b;      // Low 32 bits of the product
            backendPkg::LI:  return {16'h0000, uop.imm};
            default:         return '0;
        endcase
    endfunction

    // Sampled mid-cycle, all DUT outputs are settled here
    always @(negedge clk) begin : watch
        backendPkg::MicroOp uop;
        ExpCommit           exp;
        if (!strobeSeen && wbAck_i !== 1'b0) begin
            errorCount++;
            $display("Error at %0t: wbAck_o expected 0, got %b", $time, wbAck_i);
        end
        if (!strobeSeen && commit_i.valid !== 1'b0) begin
            errorCount++;
            $display("Error at %0t: commit_o.valid expected 0, got %b", $time, commit_i.valid);
        end
        if (wbCyc_i && wbStb_i) strobeSeen = 1'b1;

        if (wbAck_i && wbWe_i) begin
            uop = backendPkg::MicroOp'(wbDat_i[$bits(backendPkg::MicroOp)-1:0]);
            exp = '{rd: uop.rd, value: modelResult(uop)};
            if (expValid_i && expValue_i !== exp.value) begin
                errorCount++;
                $display("Stimulus table expects %h for op %0d but the model gives %h",
                         expValue_i, ackCount, exp.value);
            end
            archModel[uop.rd] = exp.value;
            expQ.push_back(exp);
            ackCount++;
        end else if (wbAck_i && wbRdDat_i !== '0) begin
            errorCount++;
            $display("Error at %0t: wbDat_o expected %h, got %h", $time, `XLEN'(0), wbRdDat_i);
        end

        if (commit_i.valid) begin
            commitCount++;
            if (expQ.size() == 0) begin
                errorCount++;
                $display("Extra commit to r%0d with no acknowledged write left to match",
                         commit_i.rd);
            end else begin
                exp = expQ.pop_front();
                if (commit_i.rd !== exp.rd) begin
                    errorCount++;
                    $display("Error at %0t: commit_o.rd expected %0d, got %0d",
                             $time, exp.rd, commit_i.rd);
                end
                if (commit_i.result !== exp.value) begin
                    errorCount++;
                    $display("Error at %0t: commit_o.result expected %h, got %h",
                             $time, exp.value, commit_i.result);
                end
                // First write of a register frees its reset mapping
                if (!committedOnce[exp.rd] &&
                    commit_i.freedPrd !== backendPkg::PhysReg'(exp.rd)) begin
                    errorCount++;
                    $display("Error at %0t: commit_o.freedPrd expected %0d, got %0d",
                             $time, exp.rd, commit_i.freedPrd);
                end
                committedOnce[exp.rd] = 1'b1;
            end
        end

        if (endOfTest_i && !endReported) begin
            endReported = 1'b1;
            if (expQ.size() != 0) begin
                errorCount++;
                $display("%0d acknowledged writes never committed", expQ.size());
            end
        end
    end

endmodule

/* test/tbBackend.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module tbBackend;
    localparam int TABLE_LEN      = 16;
    localparam int BURST_LEN      = 20;
    localparam int TOTAL_TXNS     = TABLE_LEN + BURST_LEN + 1;   // One read in between
    localparam int DRAIN_LIMIT    = 100;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_TXNS + DRAIN_LIMIT + 10;

    typedef struct packed {
        backendPkg::OpCode  op;
        backendPkg::ArchReg rd;
        backendPkg::ArchReg rs1;
        backendPkg::ArchReg rs2;
        logic [15:0]        imm;
        logic [`XLEN-1:0]   expVal;
    } StimRow;

    logic                    clk;
    logic                    rstN;
    logic                    wbCyc;
    logic                    wbStb;
    logic                    wbWe;
    logic [`WB_AW-1:0]       wbAdr;
    logic [`XLEN-1:0]        wbDat;
    logic                    wbAck;
    logic [`XLEN-1:0]        wbRdDat;
    backendPkg::CommitBundle commit;
    logic                    expValid;
    logic [`XLEN-1:0]        expValue;
    logic                    endOfTest;
    int                      errorCount;
    int                      ackCount;
    int                      commitCount;
    int                      pending;
    int                      cycleCount = 0;

    // Registers start at zero, values follow the ops in order
    StimRow stimTable [TABLE_LEN] = '{
        '{backendPkg::LI,  3'd1, 3'd0, 3'd0, 16'h0007, 32'h0000_0007},
        '{backendPkg::LI,  3'd2, 3'd0, 3'd0, 16'hffff, 32'h0000_ffff},   // Zero-extended
        '{backendPkg::ADD, 3'd3, 3'd1, 3'd2, 16'h0000, 32'h0001_0006},
        '{backendPkg::SUB, 3'd4, 3'd1, 3'd2, 16'h0000, 32'hffff_0008},
        '{backendPkg::AND, 3'd5, 3'd4, 3'd2, 16'h0000, 32'h0000_0008},
        '{backendPkg::XOR, 3'd6, 3'd4, 3'd3, 16'h0000, 32'hfffe_000e},
        '{backendPkg::MUL, 3'd7, 3'd4, 3'd4, 16'h0000, 32'hfff0_0040},
        '{backendPkg::MUL, 3'd1, 3'd7, 3'd1, 16'h0000, 32'hff90_01c0},   // RAW chain
        '{backendPkg::ADD, 3'd2, 3'd1, 3'd5, 16'h0000, 32'hff90_01c8},
        '{backendPkg::MUL, 3'd3, 3'd2, 3'd5, 16'h0000, 32'hfc80_0e40},
        '{backendPkg::XOR, 3'd0, 3'd3, 3'd1, 16'h0000, 32'h0310_0f80},
        '{backendPkg::MUL, 3'd4, 3'd5, 3'd6, 16'h0000, 32'hfff0_0070},   // Slow op first
        '{backendPkg::LI,  3'd5, 3'd0, 3'd0, 16'h1234, 32'h0000_1234},
        '{backendPkg::ADD, 3'd6, 3'd0, 3'd0, 16'h0000, 32'h0620_1f00},
        '{backendPkg::SUB, 3'd7, 3'd5, 3'd0, 16'h0000, 32'hfcf0_02b4},
        '{backendPkg::AND, 3'd2, 3'd4, 3'd6, 16'h0000, 32'h0620_0000}
    };

    miniBackend DUT (
        .clk(clk), .rstN_i(rstN), .wbCyc_i(wbCyc), .wbStb_i(wbStb), .wbWe_i(wbWe),
        .wbAdr_i(wbAdr), .wbDat_i(wbDat), .wbAck_o(wbAck), .wbDat_o(wbRdDat), .commit_o(commit)
    );

    backendChecker scoreboard (
        .clk(clk), .wbCyc_i(wbCyc), .wbStb_i(wbStb), .wbWe_i(wbWe), .wbDat_i(wbDat),
        .wbAck_i(wbAck), .wbRdDat_i(wbRdDat), .commit_i(commit), .expValid_i(expValid),
        .expValue_i(expValue), .endOfTest_i(endOfTest), .errorCount_o(errorCount),
        .ackCount_o(ackCount), .commitCount_o(commitCount), .pending_o(pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`XLEN-1:0] packOp(input backendPkg::OpCode op,
            input backendPkg::ArchReg rd, input backendPkg::ArchReg rs1,
            input backendPkg::ArchReg rs2, input logic [15:0] imm);
        backendPkg::MicroOp uop;
        uop = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
        return `XLEN'(uop);
    endfunction

    // Classic cycle, request held until ack
    task automatic busTransfer(input logic we, input logic [`XLEN-1:0] data,
            input logic hasExp, input logic [`XLEN-1:0] value);
        @(posedge clk);
        wbCyc    <= 1'b1;
        wbStb    <= 1'b1;
        wbWe     <= we;
        wbDat    <= data;
        expValid <= hasExp;
        expValue <= value;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        @(posedge clk);
        wbCyc    <= 1'b0;
        wbStb    <= 1'b0;
        wbWe     <= 1'b0;
        expValid <= 1'b0;
    endtask

    initial begin : stimulus
        backendPkg::OpCode op;
        logic [31:0]       lcgState;
        logic [31:0]       regBits;
        int                drainCycles;
        rstN      = 1'b0;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = '0;
        wbDat     = '0;
        expValid  = 1'b0;
        expValue  = '0;
        endOfTest = 1'b0;
        lcgState  = 32'h1e0e5a24;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) @(posedge clk);          // Quiet outputs before the first write

        foreach (stimTable[i]) begin
            busTransfer(1'b1, packOp(stimTable[i].op, stimTable[i].rd, stimTable[i].rs1,
                        stimTable[i].rs2, stimTable[i].imm), 1'b1, stimTable[i].expVal);
        end
        busTransfer(1'b0, '0, 1'b0, '0);

        for (int i = 0; i < BURST_LEN; i++) begin
            lcgState = lcgNext(lcgState);
            regBits  = lcgState;
            lcgState = lcgNext(lcgState);
            op = backendPkg::OpCode'(3'(regBits[31:16] % 16'd6));
            busTransfer(1'b1, packOp(op, regBits[15:13], regBits[12:10], regBits[9:7],
                        lcgState[31:16]), 1'b0, '0);
        end

        drainCycles = 0;
        while (pending > 0 && drainCycles < DRAIN_LIMIT) begin
            @(posedge clk);
            drainCycles++;
        end
        endOfTest <= 1'b1;
        repeat (2) @(posedge clk);
        $display("Summary: %0d writes acknowledged, %0d commits, %0d errors",
                 ackCount, commitCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/backendPkg.sv
hdl/instPort.sv
hdl/renameMap.sv
hdl/issueQueue.sv
hdl/latencyTimer.sv
hdl/execUnit.sv
hdl/reorderBuffer.sv
hdl/miniBackend.sv
test/backendChecker.sv
test/tbBackend.sv
